// File: hw/alu_6502.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module alu_6502 (
	input  exec_pkg::alu_func_t func,
	input  logic                decimal,
	input  logic                carry_in,
	input  exec_pkg::byte_t     sb,
	input  exec_pkg::byte_t     b,
	alu_if.alu_side             res
);
	import exec_pkg::*;

	nibble_t     lo_op;      // B nibbles, inverted for SUB
	nibble_t     hi_op;
	nibble_sum_t lo_sum;
	nibble_sum_t hi_sum;
	nibble_sum_t hi_dec_sum; // High half with the decimal half carry
	logic        dec_half_c;
	logic        dec_c;
	byte_t       add_dec;
	byte_t       sub_dec;
	byte_t       bin_out;    // Result before decimal adjust
	logic        bin_c;
	byte_t       out;
	logic        out_c;

	// Binary add and subtract in nibble halves
	always_comb begin
		lo_op  = func[0] ? ~b[3:0] : b[3:0];
		hi_op  = func[0] ? ~b[7:4] : b[7:4];
		lo_sum = {1'b0, sb[3:0]} + {1'b0, lo_op} + {4'b0, carry_in};
		hi_sum = {1'b0, sb[7:4]} + {1'b0, hi_op} + {4'b0, lo_sum[4]};
	end

	// Decimal add: low digit above 9 or half carry adds 6 and carries
	always_comb begin
		dec_half_c   = lo_sum[4] | (lo_sum[3:0] > 4'd9);
		add_dec[3:0] = dec_half_c ? lo_sum[3:0] + 4'd6 : lo_sum[3:0];
		hi_dec_sum   = {1'b0, sb[7:4]} + {1'b0, b[7:4]} + {4'b0, dec_half_c};
		dec_c        = hi_dec_sum > 5'd9;
		add_dec[7:4] = dec_c ? hi_dec_sum[3:0] + 4'd6 : hi_dec_sum[3:0];
	end

	// Decimal subtract: a borrowing digit takes 10 back
	always_comb begin
		sub_dec[3:0] = lo_sum[4] ? lo_sum[3:0] : lo_sum[3:0] + 4'd10;
		sub_dec[7:4] = hi_sum[4] ? hi_sum[3:0] : hi_sum[3:0] + 4'd10;
	end

	always_comb begin
		bin_c = 1'b0;
		case (func)
			`ALU_ADD,
			`ALU_SUB: {bin_c, bin_out} = {hi_sum[4], hi_sum[3:0], lo_sum[3:0]};
			`ALU_AND:  bin_out = sb & b;
			`ALU_ORA:  bin_out = sb | b;
			`ALU_EOR:  bin_out = sb ^ b;
			`ALU_INC:  bin_out = b + 8'd1;
			`ALU_DEC:  bin_out = b - 8'd1;
			`ALU_PASS: bin_out = b;
			`ALU_LSR:  {bin_out, bin_c} = {1'b0, b};
			`ALU_ASL:  {bin_c, bin_out} = {b, 1'b0};
			`ALU_ROR:  {bin_out, bin_c} = {carry_in, b};
			`ALU_ROL:  {bin_c, bin_out} = {b, carry_in};
			default:   bin_out = 8'h00;
		endcase

		// Only ADD and SUB ever see decimal high
		out   = bin_out;
		out_c = bin_c;
		if (decimal) begin
			out   = func[0] ? sub_dec : add_dec;
			out_c = func[0] ? bin_c : dec_c; // SUB carry is the binary borrow
		end
	end

	assign res.result = out;
	assign res.cout   = out_c;
	assign res.nout   = bin_out[7];
	assign res.zout   = (bin_out == 8'h00);
	assign res.vout   = func[0] ? (sb[7] ^ b[7]) & (bin_out[7] ^ sb[7])
	                            : (sb[7] ~^ b[7]) & (bin_out[7] ^ sb[7]);

	// The sequencer must only issue the twelve defined codes
	always_comb begin
		if (!$isunknown(func))
			assert (func <= `ALU_ROL)
				else $error("alu_6502: undefined function code %0d", func);
	end

endmodule

// File: hw/alu_if.sv
`timescale 1ns/1ps

interface alu_if;
	import exec_pkg::*;

	byte_t result; // Adjusted result byte
	logic  cout;
	logic  vout;   // From binary result
	logic  nout;   // From binary result
	logic  zout;   // From binary result

	modport alu_side (
		output result, cout, vout, nout, zout
	);

	// Write-back only needs the byte
	modport reg_side (
		input result
	);

	modport flag_side (
		input result, cout, vout, nout, zout
	);

endinterface

// File: hw/exec_pkg.sv
package exec_pkg;

	// Data byte on every bus and register
	typedef logic [7:0] byte_t;

	// One BCD digit or nibble half of a byte
	typedef logic [3:0] nibble_t;

	// Nibble sum with its carry out in the top bit
	typedef logic [4:0] nibble_sum_t;

	typedef logic [3:0] alu_func_t; // ALU function code
	typedef logic [1:0] reg_sel_t;  // A, X, Y or immediate/none
	typedef logic [2:0] flag_cmd_t; // SEC, CLC, SED, CLD, CLV

endpackage

// File: hw/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       op_valid,
	input  logic [3:0] alu_func,
	input  logic [1:0] sb_sel,
	input  logic [1:0] b_sel,
	input  logic [1:0] dst_sel,
	input  logic [7:0] imm,
	input  logic       flag_valid,
	input  logic [2:0] flag_cmd,
	output logic [7:0] a,
	output logic [7:0] x,
	output logic [7:0] y,
	output logic [7:0] p
);
	import exec_pkg::*;

	byte_t sb_bus;
	byte_t b_bus;
	logic  alu_carry;   // Current C flag
	logic  alu_decimal; // D gated to ADD and SUB

	alu_if alu_bus ();

	reg_file u_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.op_valid (op_valid),
		.sb_sel   (sb_sel),
		.b_sel    (b_sel),
		.dst_sel  (dst_sel),
		.imm      (imm),
		.res      (alu_bus),
		.sb       (sb_bus),
		.b        (b_bus),
		.a        (a),
		.x        (x),
		.y        (y)
	);

	alu_6502 u_alu (
		.func     (alu_func),
		.decimal  (alu_decimal),
		.carry_in (alu_carry),
		.sb       (sb_bus),
		.b        (b_bus),
		.res      (alu_bus)
	);

	status_unit u_status (
		.clk        (clk),
		.rst_n      (rst_n),
		.op_valid   (op_valid),
		.func       (alu_func),
		.flag_valid (flag_valid),
		.flag_cmd   (flag_cmd),
		.res        (alu_bus),
		.carry_in   (alu_carry),
		.decimal    (alu_decimal),
		.p          (p)
	);

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module reg_file (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               op_valid,
	input  exec_pkg::reg_sel_t sb_sel,
	input  exec_pkg::reg_sel_t b_sel,
	input  exec_pkg::reg_sel_t dst_sel,
	input  exec_pkg::byte_t    imm,
	alu_if.reg_side            res,
	output exec_pkg::byte_t    sb,
	output exec_pkg::byte_t    b,
	output exec_pkg::byte_t    a,
	output exec_pkg::byte_t    x,
	output exec_pkg::byte_t    y
);
	import exec_pkg::*;

	// Source register onto SB
	always_comb begin
		case (sb_sel)
			`REG_A:  sb = a;
			`REG_X:  sb = x;
			`REG_Y:  sb = y;
			default: sb = a; // Code 3 is never a source
		endcase
	end

	// B takes a register or the immediate byte
	always_comb begin
		case (b_sel)
			`REG_A:  b = a;
			`REG_X:  b = x;
			`REG_Y:  b = y;
			default: b = imm;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			a <= 8'h00;
			x <= 8'h00;
			y <= 8'h00;
		end else if (op_valid) begin
			case (dst_sel)
				`REG_A:  a <= res.result;
				`REG_X:  x <= res.result;
				`REG_Y:  y <= res.result;
				default: ; // REG_NONE, flags only
			endcase
		end
	end

	// SB has no immediate path
	a_sb_sel_reg: assert property (
		@(posedge clk) disable iff (!rst_n)
		op_valid |-> (sb_sel != `REG_IMM)
	) else $error("reg_file: sb_sel %0d is not a register", sb_sel);

endmodule

// File: hw/status_unit.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module status_unit (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                op_valid,
	input  exec_pkg::alu_func_t func,
	input  logic                flag_valid,
	input  exec_pkg::flag_cmd_t flag_cmd,
	alu_if.flag_side            res,
	output logic                carry_in,
	output logic                decimal,
	output exec_pkg::byte_t     p
);
	import exec_pkg::*;

	logic c_flag;
	logic z_flag;
	logic d_flag;
	logic v_flag;
	logic n_flag;
	logic arith_op; // ADD or SUB
	logic carry_op; // Functions whose carry reaches C

	assign arith_op = (func == `ALU_ADD) || (func == `ALU_SUB);
	assign carry_op = arith_op || (func inside {`ALU_LSR, `ALU_ASL, `ALU_ROR, `ALU_ROL});

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			c_flag <= 1'b0;
			z_flag <= 1'b0;
			d_flag <= 1'b0;
			v_flag <= 1'b0;
			n_flag <= 1'b0;
		end else if (op_valid) begin
			// N and Z follow every function, D untouched
			n_flag <= res.nout;
			z_flag <= res.zout;
			if (carry_op)
				c_flag <= res.cout;
			if (arith_op)
				v_flag <= res.vout;
		end else if (flag_valid) begin
			case (flag_cmd)
				`FLAG_SEC: c_flag <= 1'b1;
				`FLAG_CLC: c_flag <= 1'b0;
				`FLAG_SED: d_flag <= 1'b1;
				`FLAG_CLD: d_flag <= 1'b0;
				`FLAG_CLV: v_flag <= 1'b0;
				default:   ;
			endcase
		end
	end

	// Bits 2 and 4 stay 0
	always_comb begin
		p         = 8'h00;
		p[`P_C]   = c_flag;
		p[`P_Z]   = z_flag;
		p[`P_D]   = d_flag;
		p[`P_U]   = 1'b1;
		p[`P_V]   = v_flag;
		p[`P_N]   = n_flag;
	end

	assign carry_in = c_flag;
	assign decimal  = d_flag & arith_op; // BCD only for ADD and SUB

	// The sequencer issues one kind of strobe per cycle
	a_strobe_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(op_valid && flag_valid)
	) else $error("status_unit: op_valid and flag_valid high together");

	a_flag_cmd_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		flag_valid |-> (flag_cmd <= `FLAG_CLV)
	) else $error("status_unit: unknown flag command %0d", flag_cmd);

endmodule

// File: include/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// ALU function codes, bit 0 clear picks the add-side V and decimal rule
`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_AND  4'd2
`define ALU_ORA  4'd3
`define ALU_EOR  4'd4
`define ALU_INC  4'd5
`define ALU_DEC  4'd6
`define ALU_PASS 4'd7
`define ALU_LSR  4'd8
`define ALU_ASL  4'd9
`define ALU_ROR  4'd10
`define ALU_ROL  4'd11

// Register selects
`define REG_A    2'd0
`define REG_X    2'd1
`define REG_Y    2'd2
`define REG_IMM  2'd3 // As B source
`define REG_NONE 2'd3 // As destination, no write

// Flag commands
`define FLAG_SEC 3'd0
`define FLAG_CLC 3'd1
`define FLAG_SED 3'd2
`define FLAG_CLD 3'd3
`define FLAG_CLV 3'd4

// Bit positions in P
`define P_C 0
`define P_Z 1
`define P_D 3
`define P_U 5 // Always reads 1
`define P_V 6
`define P_N 7

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the exec_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_exec_unit -f sim.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_exec_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "test passed"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: sim.f
+incdir+include
hw/exec_pkg.sv
hw/alu_if.sv
hw/alu_6502.sv
hw/reg_file.sv
hw/status_unit.sv
hw/exec_unit.sv
sim/tb_exec_unit.sv

// File: sim/tb_exec_unit.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module tb_exec_unit;
	import exec_pkg::*;

	localparam int CYCLE_LIMIT = 1000; // Tests need about 450 cycles

	logic      clk;
	logic      rst_n;
	logic      op_valid;
	alu_func_t alu_func;
	reg_sel_t  sb_sel;
	reg_sel_t  b_sel;
	reg_sel_t  dst_sel;
	byte_t     imm;
	logic      flag_valid;
	flag_cmd_t flag_cmd;
	byte_t     a;
	byte_t     x;
	byte_t     y;
	byte_t     p;

	// Reference state moves ahead when a strobe is driven
	byte_t model_a;
	byte_t model_x;
	byte_t model_y;
	byte_t model_p;
	logic  model_c;
	logic  model_z;
	logic  model_d;
	logic  model_v;
	logic  model_n;
	byte_t p_mask; // Bits of p checked after this strobe

	// Expected outputs taken over on the strobe edge
	byte_t chk_a;
	byte_t chk_x;
	byte_t chk_y;
	byte_t chk_p;
	byte_t chk_mask;

	logic [31:0] rng_state;
	int cycle_count = 0;
	int err_a = 0;
	int err_x = 0;
	int err_y = 0;
	int err_p = 0;
	int test_base = 0;
	int tests_ok = 0;
	int tests_bad = 0;

	exec_unit u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.op_valid   (op_valid),
		.alu_func   (alu_func),
		.sb_sel     (sb_sel),
		.b_sel      (b_sel),
		.dst_sel    (dst_sel),
		.imm        (imm),
		.flag_valid (flag_valid),
		.flag_cmd   (flag_cmd),
		.a          (a),
		.x          (x),
		.y          (y),
		.p          (p)
	);

	always #5 clk = ~clk;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			chk_a    <= 8'h00;
			chk_x    <= 8'h00;
			chk_y    <= 8'h00;
			chk_p    <= 8'h20; // Only the unused bit reads 1
			chk_mask <= 8'hFF;
		end else if (op_valid || flag_valid) begin
			chk_a    <= model_a;
			chk_x    <= model_x;
			chk_y    <= model_y;
			chk_p    <= model_p;
			chk_mask <= p_mask;
		end
	end

	// Outputs must match the model one cycle after each strobe and hold while idle
	a_match_a: assert property (@(posedge clk) disable iff (!rst_n) a == chk_a)
		else begin
			err_a++;
			$display("ERROR %0t: a is %02h, expected %02h", $time, $sampled(a), $sampled(chk_a));
		end

	a_match_x: assert property (@(posedge clk) disable iff (!rst_n) x == chk_x)
		else begin
			err_x++;
			$display("ERROR %0t: x is %02h, expected %02h", $time, $sampled(x), $sampled(chk_x));
		end

	a_match_y: assert property (@(posedge clk) disable iff (!rst_n) y == chk_y)
		else begin
			err_y++;
			$display("ERROR %0t: y is %02h, expected %02h", $time, $sampled(y), $sampled(chk_y));
		end

	a_match_p: assert property (@(posedge clk) disable iff (!rst_n)
		(p & chk_mask) == (chk_p & chk_mask))
		else begin
			err_p++;
			$display("ERROR %0t: p is %02h, expected %02h under mask %02h", $time,
				$sampled(p), $sampled(chk_p), $sampled(chk_mask));
		end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("test failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	task automatic next_rand(output byte_t v);
		rng_state = xorshift(rng_state);
		v = rng_state[7:0];
	endtask

	function automatic byte_t to_bcd(input int v);
		return {4'(v / 10), 4'(v % 10)};
	endfunction

	function automatic byte_t pack_status();
		return {model_n, model_v, 1'b1, 1'b0, model_d, 1'b0, model_z, model_c};
	endfunction

	function automatic byte_t reg_value(input reg_sel_t sel, input byte_t im);
		case (sel)
			`REG_A:  return model_a;
			`REG_X:  return model_x;
			`REG_Y:  return model_y;
			default: return im;
		endcase
	endfunction

	function automatic int error_total();
		return err_a + err_x + err_y + err_p;
	endfunction

	// Gives the result, the binary result for N and Z, carry and overflow
	task automatic model_alu(input alu_func_t f, input byte_t s, input byte_t bv,
			input logic dec, output byte_t res, output byte_t bin,
			output logic c_out, output logic v_out);
		int sum;
		int ssum; // Signed view for V
		int ds;
		int db;
		c_out = model_c;
		v_out = model_v;
		ssum  = 0;
		case (f)
			`ALU_ADD: begin
				sum   = int'(s) + int'(bv) + int'(model_c);
				ssum  = int'($signed(s)) + int'($signed(bv)) + int'(model_c);
				c_out = sum > 255;
			end
			`ALU_SUB: begin
				sum   = int'(s) - int'(bv) - 1 + int'(model_c);
				ssum  = int'($signed(s)) - int'($signed(bv)) - 1 + int'(model_c);
				c_out = sum >= 0; // Set means no borrow
			end
			`ALU_AND:  sum = int'(s & bv);
			`ALU_ORA:  sum = int'(s | bv);
			`ALU_EOR:  sum = int'(s ^ bv);
			`ALU_INC:  sum = int'(bv) + 1;
			`ALU_DEC:  sum = int'(bv) - 1;
			`ALU_PASS: sum = int'(bv);
			`ALU_LSR: begin
				sum   = int'(bv) / 2;
				c_out = bv[0];
			end
			`ALU_ASL: begin
				sum   = int'(bv) * 2;
				c_out = bv[7];
			end
			`ALU_ROR: begin
				sum   = int'(bv) / 2 + 128 * int'(model_c);
				c_out = bv[0];
			end
			`ALU_ROL: begin
				sum   = int'(bv) * 2 + int'(model_c);
				c_out = bv[7];
			end
			default:  sum = 0;
		endcase
		bin = 8'(sum);
		res = bin;
		if (f == `ALU_ADD || f == `ALU_SUB)
			v_out = (ssum > 127) || (ssum < -128);
		if (dec) begin
			ds = int'(s[7:4]) * 10 + int'(s[3:0]);
			db = int'(bv[7:4]) * 10 + int'(bv[3:0]);
			if (f == `ALU_ADD) begin
				sum   = ds + db + int'(model_c);
				c_out = sum >= 100;
			end else begin
				sum   = ds - db - 1 + int'(model_c);
				c_out = sum >= 0;
			end
			res = to_bcd((sum + 100) % 100);
		end
	endtask

	task automatic alu_op(input alu_func_t f, input reg_sel_t s_sel, input reg_sel_t bs,
			input reg_sel_t dst, input byte_t im);
		byte_t res;
		byte_t bin;
		logic  c_out;
		logic  v_out;
		logic  arith;
		arith = (f == `ALU_ADD) || (f == `ALU_SUB);
		model_alu(f, reg_value(s_sel, im), reg_value(bs, im), model_d && arith,
			res, bin, c_out, v_out);
		model_n = bin[7];
		model_z = (bin == 8'h00);
		if (arith || f >= `ALU_LSR)
			model_c = c_out;
		if (arith)
			model_v = v_out;
		case (dst)
			`REG_A:  model_a = res;
			`REG_X:  model_x = res;
			`REG_Y:  model_y = res;
			default: ;
		endcase
		model_p  = pack_status();
		p_mask   = (model_d && arith) ? 8'h3D : 8'hFF; // Decimal N, Z and V not compared
		alu_func = f;
		sb_sel   = s_sel;
		b_sel    = bs;
		dst_sel  = dst;
		imm      = im;
		op_valid = 1'b1;
		@(negedge clk);
		op_valid = 1'b0;
	endtask

	task automatic flag_op(input flag_cmd_t cmd);
		case (cmd)
			`FLAG_SEC: model_c = 1'b1;
			`FLAG_CLC: model_c = 1'b0;
			`FLAG_SED: model_d = 1'b1;
			`FLAG_CLD: model_d = 1'b0;
			`FLAG_CLV: model_v = 1'b0;
			default:   ;
		endcase
		model_p    = pack_status();
		p_mask     = 8'hFF;
		flag_cmd   = cmd;
		flag_valid = 1'b1;
		@(negedge clk);
		flag_valid = 1'b0;
	endtask

	// Two idle cycles let the last check fire
	task automatic end_test(input int num, input string name);
		int errs;
		repeat (2) @(negedge clk);
		errs = error_total() - test_base;
		if (errs == 0) begin
			tests_ok++;
			$display("Test %0d %s: ok", num, name);
		end else begin
			tests_bad++;
			$display("Test %0d %s: %0d mismatches", num, name, errs);
		end
		test_base = error_total();
	endtask

	initial begin
		byte_t     r;
		byte_t     im;
		alu_func_t f;
		clk        = 1'b0;
		rst_n      = 1'b0;
		op_valid   = 1'b0;
		alu_func   = `ALU_ADD;
		sb_sel     = `REG_A;
		b_sel      = `REG_A;
		dst_sel    = `REG_NONE;
		imm        = 8'h00;
		flag_valid = 1'b0;
		flag_cmd   = `FLAG_CLC;
		model_a    = 8'h00;
		model_x    = 8'h00;
		model_y    = 8'h00;
		model_c    = 1'b0;
		model_z    = 1'b0;
		model_d    = 1'b0;
		model_v    = 1'b0;
		model_n    = 1'b0;
		model_p    = pack_status();
		p_mask     = 8'hFF;
		rng_state  = 32'd82;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		repeat (6) @(negedge clk);
		end_test(1, "reset and idle");

		flag_op(`FLAG_SEC); // C has to survive the logic ops
		for (int i = 0; i < 60; i++) begin
			next_rand(r);
			f = 4'(2 + int'(r) % 6); // AND up to PASS
			next_rand(im);
			if (i % 10 == 0)
				im = 8'h00;
			else if (i % 10 == 5)
				im = im | 8'h80;
			next_rand(r);
			alu_op(f, 2'(int'(r[3:0]) % 3), `REG_IMM, 2'(int'(r[7:4]) % 3), im);
		end
		end_test(2, "logic, pass, inc and dec");

		// Results rotate A to X to Y and back
		for (int i = 0; i < 80; i++) begin
			next_rand(r);
			flag_op(r[0] ? `FLAG_SEC : `FLAG_CLC);
			next_rand(im);
			alu_op(r[1] ? `ALU_SUB : `ALU_ADD, 2'(i % 3), `REG_IMM, 2'((i + 1) % 3), im);
		end
		end_test(3, "binary add and subtract");

		for (int i = 0; i < 40; i++) begin
			next_rand(r);
			next_rand(im);
			alu_op(4'(8 + int'(r) % 4), `REG_A, `REG_IMM, 2'(i % 3), im);
		end
		end_test(4, "shifts and rotates");

		flag_op(`FLAG_SED);
		for (int i = 0; i < 60; i++) begin
			next_rand(r);
			alu_op(`ALU_PASS, `REG_A, `REG_IMM, `REG_A,
				{4'(int'(r[7:4]) % 10), 4'(int'(r[3:0]) % 10)});
			next_rand(r);
			next_rand(im);
			alu_op(r[0] ? `ALU_SUB : `ALU_ADD, `REG_A, `REG_IMM, `REG_X,
				{4'(int'(im[7:4]) % 10), 4'(int'(im[3:0]) % 10)});
		end
		flag_op(`FLAG_CLD);
		flag_op(`FLAG_CLC);
		alu_op(`ALU_PASS, `REG_A, `REG_IMM, `REG_A, 8'h38);
		alu_op(`ALU_ADD, `REG_A, `REG_IMM, `REG_Y, 8'h27); // Binary 5F where BCD gives 65
		end_test(5, "decimal add and subtract");

		flag_op(`FLAG_SEC);
		flag_op(`FLAG_CLC);
		flag_op(`FLAG_SED);
		flag_op(`FLAG_CLD);
		alu_op(`ALU_PASS, `REG_A, `REG_IMM, `REG_A, 8'h50);
		alu_op(`ALU_ADD, `REG_A, `REG_IMM, `REG_X, 8'h50); // Sets V
		flag_op(`FLAG_CLV);
		alu_op(`ALU_PASS, `REG_A, `REG_IMM, `REG_NONE, 8'h00);
		alu_op(`ALU_ADD, `REG_X, `REG_IMM, `REG_NONE, 8'hF0);
		end_test(6, "flag commands and no-write ops");

		$display("Tests ok: %0d, tests with mismatches: %0d, mismatches: %0d",
			tests_ok, tests_bad, error_total());
		if (tests_bad == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule
